// File: Makefile
# Verilator build and run for the float/int conversion unit

VERILATOR ?= verilator
TOP       ?= cast_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := ** FAIL **
PASS_MSG  := ** PASS **
SOURCES   := $(wildcard src/*.sv test/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+include
src/cast_pkg.sv
src/cast_ctrl.sv
src/cast_normalize.sv
src/cast_align.sv
src/cast_round.sv
src/cast_top.sv
test/cast_checker.sv
test/tb_clock.sv
test/cast_tb.sv

// File: include/cast_macros.svh
/* word, float field and internal exponent widths, bias and status width
   for the float/int conversion unit */
`ifndef CAST_MACROS_SVH
`define CAST_MACROS_SVH

// ------------------------------
// operand and float format
// ------------------------------
`define CAST_WORD_W    32  // operand and result word
`define CAST_EXP_BITS  8   // single precision exponent field
`define CAST_MAN_BITS  23  // single precision fraction field
`define CAST_BIAS      127

// ------------------------------
// internal datapath
// ------------------------------
`define CAST_IEXP_W    10  // signed unbiased exponent, covers -151..+158
`define CAST_STATUS_W  5   // NV DZ OF UF NX

`endif

// File: src/cast_align.sv
/* cast_align: exponent rebias, mantissa shift to destination position,
   round/sticky extraction and integer overflow detection */
`timescale 1ns/1ns
`include "cast_macros.svh"

module cast_align import cast_pkg::*; (
  input  logic  sign_i,
  input  exp_t  exp_i,
  input  mant_t mant_i,
  input  logic  f2i_i,
  input  logic  op_mod_i,
  output word_t abs_o,   // magnitude before rounding
  output rs_t   rs_o,
  output logic  of_o     // integer out of range
);

  localparam int unsigned PRE_W      = 2 * `CAST_WORD_W + 1;
  localparam int unsigned SHAMT_W    = $clog2(`CAST_WORD_W) + 1;
  localparam int unsigned INT_STICKY = `CAST_WORD_W;                        // below int and R
  localparam int unsigned FP_STICKY  = 2 * `CAST_WORD_W - `CAST_MAN_BITS - 1; // below frac and R

  logic [PRE_W-1:0]          preshift, shifted;
  logic [SHAMT_W-1:0]        shamt;
  logic                      min_int;  // exactly -2^31 into signed
  logic                      int_of;
  word_t                     final_int;
  logic [`CAST_MAN_BITS-1:0] final_frac;
  rs_t                       int_rs, fp_rs;
  exp_t                      biased_exp;

  assign min_int = sign_i & ~op_mod_i & (exp_i == exp_t'(`CAST_WORD_W - 1)) &
                   (mant_i == {1'b1, {(`CAST_WORD_W-1){1'b0}}});

  // unsigned range one bit wider
  assign int_of = f2i_i & ~min_int &
                  (exp_i >= exp_t'(`CAST_WORD_W - 1) + exp_t'(op_mod_i));

  // ------------------------------
  // shift amount
  // ------------------------------
  always_comb begin
    shamt = '0; // i2f keeps the mantissa where it is
    if (f2i_i) begin
      if (int_of) begin
        shamt = '0;
      end else if (exp_i < exp_t'(-1)) begin
        shamt = SHAMT_W'(`CAST_WORD_W + 1);             // everything into sticky
      end else begin
        shamt = SHAMT_W'(exp_t'(`CAST_WORD_W - 1) - exp_i); // binary point to bit 0
      end
    end
  end

  assign preshift = {mant_i, {(PRE_W-`CAST_WORD_W){1'b0}}};
  assign shifted  = preshift >> shamt;

  // integer part plus round bit, rest collapses to sticky
  assign {final_int, int_rs[1]} = shifted[PRE_W-1 -: `CAST_WORD_W+1];
  assign int_rs[0]              = |shifted[INT_STICKY-1:0];

  // hidden bit dropped for the float fraction
  assign {final_frac, fp_rs[1]} = shifted[PRE_W-2 -: `CAST_MAN_BITS+1];
  assign fp_rs[0]               = |shifted[FP_STICKY-1:0];

  assign biased_exp = exp_i + exp_t'(`CAST_BIAS); // never above 158 here

  assign abs_o = f2i_i ? final_int : {1'b0, biased_exp[`CAST_EXP_BITS-1:0], final_frac};
  assign rs_o  = f2i_i ? int_rs : fp_rs;
  assign of_o  = int_of;

endmodule

// File: src/cast_ctrl.sv
/* cast_ctrl: valid/ready handshake, op decode, output register stage */
`timescale 1ns/1ns

module cast_ctrl import cast_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // upstream
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  cast_op_e op_i,
  output logic     f2i_o,       // datapath direction select
  // from datapath
  input  word_t    result_i,
  input  status_t  status_i,
  // downstream
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output word_t    result_o,
  output status_t  status_o
);

  logic accept; // beat taken this cycle

  assign f2i_o = (op_i == OP_F2I);

  // stage free when empty or draining this cycle
  assign in_ready_o = out_ready_i | ~out_valid_o;
  assign accept     = in_valid_i & in_ready_o;

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
      result_o    <= '0;
      status_o    <= '0;
    end else if (accept) begin
      out_valid_o <= 1'b1;     // new beat replaces any leaving one
      result_o    <= result_i;
      status_o    <= status_i;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;     // drained, nothing behind it
    end
  end

endmodule

// File: src/cast_normalize.sv
/* cast_normalize: float unpack/classify or integer magnitude,
   then leading-zero normalization and unbiased exponent */
`timescale 1ns/1ns
`include "cast_macros.svh"

module cast_normalize import cast_pkg::*; (
  input  word_t operand_i,
  input  logic  f2i_i,
  input  logic  op_mod_i,   // unsigned integer when high
  output logic  sign_o,
  output exp_t  exp_o,
  output mant_t mant_o,
  output logic  is_zero_o,
  output logic  is_inf_o,
  output logic  is_nan_o,
  output logic  is_snan_o
);

  localparam int unsigned LZC_W = $clog2(`CAST_WORD_W) + 1; // counts 0..32

  logic [`CAST_EXP_BITS-1:0] exp_field;
  logic [`CAST_MAN_BITS-1:0] frac_field;
  logic                      exp_zero, exp_ones, frac_zero;
  logic                      is_normal, is_subnormal;
  logic                      int_sign;
  word_t                     int_mag;
  mant_t                     enc_mant;  // before normalization
  logic [LZC_W-1:0]          lzc;
  exp_t                      fp_exp, int_exp;

  // ------------------------------
  // float classification
  // ------------------------------
  assign exp_field  = operand_i[`CAST_WORD_W-2 -: `CAST_EXP_BITS];
  assign frac_field = operand_i[`CAST_MAN_BITS-1:0];
  assign exp_zero   = (exp_field == '0);
  assign exp_ones   = (exp_field == '1);
  assign frac_zero  = (frac_field == '0);

  assign is_normal    = ~exp_zero & ~exp_ones;
  assign is_subnormal = exp_zero & ~frac_zero;

  assign is_inf_o  = f2i_i & exp_ones & frac_zero;
  assign is_nan_o  = f2i_i & exp_ones & ~frac_zero;
  assign is_snan_o = is_nan_o & ~frac_field[`CAST_MAN_BITS-1]; // quiet bit clear
  assign is_zero_o = f2i_i ? (exp_zero & frac_zero) : (int_mag == '0);

  // ------------------------------
  // integer source
  // ------------------------------
  assign int_sign = operand_i[`CAST_WORD_W-1] & ~op_mod_i; // unsigned never negative
  assign int_mag  = int_sign ? word_t'(-operand_i) : operand_i;

  // hidden bit joins the fraction, zero padded on top
  assign enc_mant = f2i_i ? mant_t'({is_normal, frac_field}) : int_mag;

  // leading zero count, highest set bit wins
  always_comb begin
    lzc = LZC_W'(`CAST_WORD_W);
    for (int i = 0; i < `CAST_WORD_W; i++) begin
      if (enc_mant[i]) lzc = LZC_W'(`CAST_WORD_W - 1 - i);
    end
  end

  assign mant_o = enc_mant << lzc;

  // subnormals use exponent 1, pad offset undoes the top zeros
  assign fp_exp  = exp_t'(exp_field) + exp_t'(is_subnormal) - exp_t'(`CAST_BIAS)
                   - exp_t'(lzc) + exp_t'(`CAST_WORD_W - 1 - `CAST_MAN_BITS);
  assign int_exp = exp_t'(`CAST_WORD_W - 1) - exp_t'(lzc);

  assign exp_o  = f2i_i ? fp_exp : int_exp;
  assign sign_o = f2i_i ? operand_i[`CAST_WORD_W-1] : int_sign;

endmodule

// File: src/cast_pkg.sv
/* vector typedefs and operation / rounding-mode enums for the conversion unit */
`include "cast_macros.svh"

package cast_pkg;

  // ------------------------------
  // datapath vectors
  // ------------------------------
  typedef logic        [`CAST_WORD_W-1:0]   word_t;   // operand or result
  typedef logic signed [`CAST_IEXP_W-1:0]   exp_t;    // unbiased exponent
  typedef logic        [`CAST_WORD_W-1:0]   mant_t;   // leading one at msb
  typedef logic        [1:0]                rs_t;     // {round, sticky}
  typedef logic        [`CAST_STATUS_W-1:0] status_t; // NV DZ OF UF NX, msb first

  // ------------------------------
  // control encodings
  // ------------------------------
  typedef enum logic {
    OP_F2I = 1'b0, // float to int
    OP_I2F = 1'b1  // int to float
  } cast_op_e;

  typedef enum logic [2:0] {
    RNE = 3'd0, // nearest, ties to even
    RTZ = 3'd1, // toward zero
    RDN = 3'd2, // toward -inf
    RUP = 3'd3, // toward +inf
    RMM = 3'd4  // nearest, ties away
  } rnd_mode_e;

endpackage

// File: src/cast_round.sv
/* cast_round: rounding by mode, sign application, integer special
   results and status flags */
`timescale 1ns/1ns
`include "cast_macros.svh"

module cast_round import cast_pkg::*; (
  input  word_t     abs_i,
  input  rs_t       rs_i,
  input  logic      sign_i,
  input  logic      of_i,
  input  logic      is_zero_i,
  input  logic      is_inf_i,
  input  logic      is_nan_i,
  input  logic      is_snan_i,
  input  logic      f2i_i,
  input  logic      op_mod_i,
  input  rnd_mode_e rnd_mode_i,
  output word_t     result_o,
  output status_t   status_o
);

  logic  rnd_bit, sticky, lsb;
  logic  round_up;
  word_t rounded_abs;
  word_t rounded_int;   // two's complement form
  logic  rounded_zero;
  logic  int_special;
  word_t special_int;
  word_t float_res;
  logic  nv, nx;

  assign {rnd_bit, sticky} = rs_i;
  assign lsb               = abs_i[0];

  // ------------------------------
  // rounding decision
  // ------------------------------
  always_comb begin
    case (rnd_mode_i)
      RNE:     round_up = rnd_bit & (sticky | lsb);    // tie goes to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (rnd_bit | sticky) & sign_i;
      RUP:     round_up = (rnd_bit | sticky) & ~sign_i;
      RMM:     round_up = rnd_bit;                     // tie away from zero
      default: round_up = 1'b0;
    endcase
  end

  // float carry ripples into the exponent field
  assign rounded_abs = abs_i + word_t'(round_up);

  assign rounded_int  = sign_i ? word_t'(-rounded_abs) : rounded_abs;
  assign rounded_zero = (rounded_int == '0);

  // ------------------------------
  // integer special cases
  // ------------------------------
  assign int_special = is_nan_i | is_inf_i | of_i |
                       (sign_i & op_mod_i & ~rounded_zero); // negative into unsigned

  // positive saturation, inverted for negative non-NaN
  always_comb begin
    special_int = {op_mod_i, {(`CAST_WORD_W-1){1'b1}}};
    if (sign_i & ~is_nan_i) special_int = ~special_int;
  end

  // integer zero comes out as +0.0
  assign float_res = is_zero_i ? '0 : {sign_i, rounded_abs[`CAST_WORD_W-2:0]};

  // ------------------------------
  // result and flags
  // ------------------------------
  // a signalling NaN is always invalid
  assign nv = f2i_i & (int_special | is_snan_i);
  assign nx = |rs_i;

  always_comb begin
    if (f2i_i) begin
      result_o = int_special ? special_int : rounded_int;
    end else begin
      result_o = float_res;
    end
    status_o = {nv, 3'b000, nx & ~nv}; // DZ, OF, UF never raised
  end

endmodule

// File: src/cast_top.sv
/* cast_top: float/int conversion unit, control plus three-stage
   combinational datapath */
`timescale 1ns/1ns

module cast_top import cast_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  word_t     operand_i,
  input  cast_op_e  op_i,
  input  logic      op_mod_i,
  input  rnd_mode_e rnd_mode_i,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output word_t     result_o,
  output status_t   status_o
);

  logic    f2i;
  logic    sign;
  exp_t    exp_n;    // normalized exponent
  mant_t   mant_n;   // normalized mantissa
  logic    is_zero, is_inf, is_nan, is_snan;
  word_t   abs_val;
  rs_t     rs;
  logic    of;
  word_t   result_d;
  status_t status_d;

  cast_ctrl i_cast_ctrl (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .op_i        ( op_i        ),
    .f2i_o       ( f2i         ),
    .result_i    ( result_d    ),
    .status_i    ( status_d    ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    )
  );

  cast_normalize i_cast_normalize (
    .operand_i ( operand_i ),
    .f2i_i     ( f2i       ),
    .op_mod_i  ( op_mod_i  ),
    .sign_o    ( sign      ),
    .exp_o     ( exp_n     ),
    .mant_o    ( mant_n    ),
    .is_zero_o ( is_zero   ),
    .is_inf_o  ( is_inf    ),
    .is_nan_o  ( is_nan    ),
    .is_snan_o ( is_snan   )
  );

  cast_align i_cast_align (
    .sign_i   ( sign     ),
    .exp_i    ( exp_n    ),
    .mant_i   ( mant_n   ),
    .f2i_i    ( f2i      ),
    .op_mod_i ( op_mod_i ),
    .abs_o    ( abs_val  ),
    .rs_o     ( rs       ),
    .of_o     ( of       )
  );

  cast_round i_cast_round (
    .abs_i      ( abs_val    ),
    .rs_i       ( rs         ),
    .sign_i     ( sign       ),
    .of_i       ( of         ),
    .is_zero_i  ( is_zero    ),
    .is_inf_i   ( is_inf     ),
    .is_nan_i   ( is_nan     ),
    .is_snan_i  ( is_snan    ),
    .f2i_i      ( f2i        ),
    .op_mod_i   ( op_mod_i   ),
    .rnd_mode_i ( rnd_mode_i ),
    .result_o   ( result_d   ),
    .status_o   ( status_d   )
  );

endmodule

// File: test/cast_checker.sv
/* handshake assertions for cast_top, attached by bind */
`timescale 1ns/1ns

module cast_checker import cast_pkg::*; (
  input logic    clk_i,
  input logic    rst_i,
  input logic    in_ready_i,
  input logic    out_valid_i,
  input logic    out_ready_i,
  input word_t   result_i,
  input status_t status_i
);

  int unsigned fail_cnt = 0;  // read by the testbench at the end

  // ------------------------------
  // handshake rules
  // ------------------------------
  reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !out_valid_i)
    else begin
      fail_cnt++;
      $error("out_valid_o high in the cycle after reset");
    end

  // stalled output must not move
  stall_holds_output: assert property (@(posedge clk_i) disable iff (rst_i)
      (out_valid_i && !out_ready_i) |=>
      (out_valid_i && $stable(result_i) && $stable(status_i)))
    else begin
      fail_cnt++;
      $error("output changed while stalled by out_ready_i");
    end

  empty_means_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      !out_valid_i |-> in_ready_i)
    else begin
      fail_cnt++;
      $error("in_ready_o low with an empty output stage");
    end

endmodule

bind cast_top cast_checker i_cast_checker (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .in_ready_i  ( in_ready_o  ),
  .out_valid_i ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .result_i    ( result_o    ),
  .status_i    ( status_o    )
);

// File: test/cast_tb.sv
/* testbench for cast_top: directed and random float/int conversions,
   reference model, output scoreboard and final report */
`timescale 1ns/1ns
`include "cast_macros.svh"

module cast_tb import cast_pkg::*; ();

  localparam int unsigned SEED    = 32'hb1c3786d;
  localparam int unsigned TIMEOUT = 200;  // cycles per wait
  localparam int          SETTLE  = 5;    // ns after falling edge, before rising edge
  localparam status_t     ST_NV   = 5'b10000;
  localparam status_t     ST_NX   = 5'b00001;
  localparam longint      INT_MIN  = -64'sd2147483648;
  localparam longint      INT_MAX  = 64'sd2147483647;
  localparam longint      UINT_MAX = 64'sd4294967295;

  localparam word_t F2I_DIRECT [12] = '{
    32'h3f800000, 32'hbf800000, 32'h3f000000, 32'hbf000000, // +-1.0, +-0.5
    32'h3fc00000, 32'hbfc00000, 32'h40200000, 32'hc0200000, // +-1.5, +-2.5
    32'h42c80000, 32'h42c90000, 32'h00000000, 32'h80000000  // 100.0, 100.5, +-0
  };
  localparam word_t F2I_SPECIAL [14] = '{
    32'h7fc00000, 32'h7fa00000, 32'hffc00000,  // qnan, snan, negative qnan
    32'h7f800000, 32'hff800000,                // +-inf
    32'h4f000000, 32'hcf000000, 32'hcf000001,  // 2^31, -2^31, just beyond -2^31
    32'h4f800000, 32'h4f7fffff, 32'h5f000000,  // 2^32, largest below 2^32, 2^63
    32'hbe99999a, 32'h00000001, 32'h807fffff   // -0.3, subnormals
  };
  localparam word_t I2F_DIRECT [8] = '{
    32'h00000000, 32'h80000000, 32'h7fffffff, 32'hffffffff,
    32'h01000001, 32'h01000003, 32'h00ffffff, 32'h00000001  // around 2^24
  };

  logic      clk_i, rst_i;
  logic      in_valid_i, in_ready_o, op_mod_i;
  logic      out_valid_o, out_ready_i;
  word_t     operand_i, result_o;
  cast_op_e  op_i;
  rnd_mode_e rnd_mode_i;
  status_t   status_o;

  // scoreboard, one entry per accepted beat
  word_t       res_q [$];
  status_t     sts_q [$];
  string       name_q [$];
  string       beat_name;
  int unsigned n_err = 0;
  int unsigned n_chk = 0;
  int unsigned seed_val;
  logic        bp_en = 1'b0;  // random out_ready_i stalls
  logic        hung  = 1'b0;  // a wait timed out

  tb_clock #(.PERIOD(20)) i_tb_clock (.clk_o(clk_i));

  cast_top i_cast_top (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .operand_i   ( operand_i   ),
    .op_i        ( op_i        ),
    .op_mod_i    ( op_mod_i    ),
    .rnd_mode_i  ( rnd_mode_i  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    )
  );

  // ------------------------------
  // reference model
  // ------------------------------
  // discarded part vs one half: 0 none, 1 below, 2 tie, 3 above
  function automatic int frac_class(input longint unsigned rem, input longint unsigned half);
    if (rem == 0) return 0;
    if (rem < half) return 1;
    if (rem == half) return 2;
    return 3;
  endfunction

  // magnitude bump for the given mode
  function automatic logic round_incr(input logic lsb, input int cls, input logic neg,
                                      input rnd_mode_e mode);
    case (mode)
      RNE:     return (cls == 3) || (cls == 2 && lsb);
      RTZ:     return 1'b0;
      RDN:     return neg && (cls != 0);
      RUP:     return !neg && (cls != 0);
      RMM:     return cls >= 2;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void cast_ref(input word_t opd, input cast_op_e op, input logic umod,
                                   input rnd_mode_e mode, output word_t res,
                                   output status_t sts);
    logic            neg;
    int              e, sh, p, cls;
    longint unsigned sig, mag;
    longint          v;
    res = '0;
    sts = '0;
    cls = 0;
    if (op == OP_F2I) begin
      neg = opd[31];
      e   = int'(opd[30:23]);
      if (e == 255) begin                       // nan saturates positive
        res = (neg && (opd[22:0] == '0)) ? {~umod, 31'h0} : {umod, 31'h7fffffff};
        sts = ST_NV;
      end else if (e >= `CAST_BIAS + 32) begin  // |x| >= 2^32
        res = neg ? {~umod, 31'h0} : {umod, 31'h7fffffff};
        sts = ST_NV;
      end else begin
        sig = {40'd0, e != 0, opd[22:0]};       // value = sig * 2^sh
        sh  = (e == 0 ? 1 : e) - `CAST_BIAS - `CAST_MAN_BITS;
        mag = sig;
        if (sh >= 0) begin
          mag = sig << sh;
        end else begin
          sh  = (-sh > 40) ? 40 : -sh;          // deeper shifts only feed sticky
          mag = sig >> sh;
          cls = frac_class(sig & ((64'd1 << sh) - 1), 64'd1 << (sh - 1));
        end
        if (round_incr(mag[0], cls, neg, mode))
          mag++;
        v = neg ? -longint'(mag) : longint'(mag);
        if (umod ? (v < 0 || v > UINT_MAX) : (v < INT_MIN || v > INT_MAX)) begin
          res = (v < 0) ? {~umod, 31'h0} : {umod, 31'h7fffffff};
          sts = ST_NV;
        end else begin
          res = v[31:0];
          sts = (cls != 0) ? ST_NX : '0;
        end
      end
    end else begin
      neg = ~umod & opd[31];
      mag = neg ? (64'd1 << 32) - 64'(opd) : 64'(opd);
      if (mag != 0) begin
        p = 31;
        while (!mag[p])
          p--;
        e = `CAST_BIAS + p;
        if (p <= `CAST_MAN_BITS) begin
          mag = mag << (`CAST_MAN_BITS - p);    // exact
        end else begin
          sh  = p - `CAST_MAN_BITS;
          cls = frac_class(mag & ((64'd1 << sh) - 1), 64'd1 << (sh - 1));
          mag = mag >> sh;
          if (round_incr(mag[0], cls, neg, mode))
            mag++;
          if (mag[24]) begin                    // carried into next binade
            mag = mag >> 1;
            e++;
          end
        end
        res = {neg, e[7:0], mag[22:0]};
        sts = (cls != 0) ? ST_NX : '0;
      end
    end
  endfunction

  // ------------------------------
  // stimulus and checks
  // ------------------------------
  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    n_chk++;
    if (exp_v !== act_v) begin
      n_err++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  // holds in_valid_i until the beat is taken, returns after that rising edge
  task automatic send(input string grp, input word_t opd, input cast_op_e op,
                      input logic umod, input rnd_mode_e mode);
    word_t       res;
    status_t     sts;
    int unsigned waited;
    logic        taken;
    cast_ref(opd, op, umod, mode, res, sts);
    @(negedge clk_i);
    operand_i  = opd;
    op_i       = op;
    op_mod_i   = umod;
    rnd_mode_i = mode;
    in_valid_i = 1'b1;
    waited     = 0;
    taken      = 1'b0;
    while (!taken && !hung) begin
      #SETTLE;
      taken = in_ready_o;  // stable until the next rising edge
      if (!taken) begin
        waited++;
        if (waited > TIMEOUT) begin
          hung = 1'b1;
          n_err++;
          $display("ERROR: input beat never accepted, in_ready_o stuck low (%s)", grp);
        end else begin
          @(negedge clk_i);
        end
      end
    end
    if (taken) begin
      res_q.push_back(res);
      sts_q.push_back(sts);
      name_q.push_back($sformatf("%s %h %s %s", grp, opd, mode.name(),
                                 umod ? "unsigned" : "signed"));
      @(posedge clk_i);
    end
  endtask

  // all five modes, signed and unsigned
  task automatic sweep(input string grp, input word_t opd, input cast_op_e op);
    for (int m = 0; m < 5; m++) begin
      send(grp, opd, op, 1'b0, rnd_mode_e'(m));
      send(grp, opd, op, 1'b1, rnd_mode_e'(m));
    end
  endtask

  task automatic send_random(input string grp, input cast_op_e op, input logic near_int);
    word_t     opd;
    logic      umod;
    rnd_mode_e mode;
    opd  = $urandom();
    umod = 1'($urandom_range(0, 1));
    mode = rnd_mode_e'($urandom_range(0, 4));
    if (near_int && op == OP_F2I)
      opd[30:23] = 8'($urandom_range(118, 162));  // about 2^-9 .. 2^35
    send(grp, opd, op, umod, mode);
  endtask

  // idle inputs until every expected result came out
  task automatic drain();
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    in_valid_i = 1'b0;
    while (res_q.size() != 0 && !hung) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        hung = 1'b1;
        n_err++;
        $display("ERROR: %0d results never came out of the DUT", res_q.size());
      end
    end
  endtask

  // random stalls on the output side
  initial begin : ready_driver
    out_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      out_ready_i = bp_en ? ($urandom_range(0, 2) != 0) : 1'b1;
    end
  end

  // one scoreboard pop per transferred beat
  initial begin : compare_outputs
    forever begin
      @(negedge clk_i);
      #SETTLE;
      if (!rst_i && out_valid_o && out_ready_i) begin
        if (res_q.size() == 0) begin
          n_err++;
          $display("ERROR: output beat %h with no accepted input left", result_o);
        end else begin
          beat_name = name_q.pop_front();
          check_val({beat_name, " result"}, res_q.pop_front(), result_o);
          check_val({beat_name, " status"}, 32'(sts_q.pop_front()), 32'(status_o));
        end
      end
    end
  end

  initial begin : run_tests
    seed_val   = $urandom(SEED);
    rst_i      = 1'b1;
    in_valid_i = 1'b0;
    operand_i  = '0;
    op_i       = OP_F2I;
    op_mod_i   = 1'b0;
    rnd_mode_i = RNE;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;

    // empty after reset, first beat one cycle later
    @(negedge clk_i);
    #SETTLE;
    check_val("out_valid_o after reset", 32'd0, 32'(out_valid_o));
    send("first beat", 32'h3fc00000, OP_F2I, 1'b0, RNE);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    #SETTLE;
    check_val("first beat latency", 32'd1, 32'(out_valid_o));

    for (int i = 0; i < 12; i++)
      sweep("f2i directed", F2I_DIRECT[i], OP_F2I);
    for (int i = 0; i < 14; i++)
      sweep("f2i special", F2I_SPECIAL[i], OP_F2I);
    for (int i = 0; i < 8; i++)
      sweep("i2f directed", I2F_DIRECT[i], OP_I2F);
    for (int i = 0; i < 300; i++)
      send_random("i2f random", OP_I2F, 1'b0);
    for (int i = 0; i < 400; i++)
      send_random("f2i random", OP_F2I, i[0]);  // every other one near int range
    drain();

    // back-to-back inputs against a stalling output
    bp_en = 1'b1;
    for (int i = 0; i < 400; i++)
      send_random("backpressure", cast_op_e'($urandom_range(0, 1)), 1'b1);
    drain();
    bp_en = 1'b0;
    repeat (5) @(negedge clk_i);  // catch stray extra beats

    $display("checks: %0d, errors: %0d, assertion failures: %0d", n_chk, n_err,
             i_cast_top.i_cast_checker.fail_cnt);
    if (n_err == 0 && i_cast_top.i_cast_checker.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: test/tb_clock.sv
/* free-running testbench clock, 20 ns period */
`timescale 1ns/1ns

module tb_clock #(
  parameter int unsigned PERIOD = 20  // ns
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;  // first rising edge at PERIOD/2
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule
